/* tb.f */
+incdir+include
source/dm_pkg.sv
source/access_sequencer.sv
source/memory_bank.sv
source/burst_collector.sv
source/dm_subsystem.sv
verif/dm_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it; the exit status is the simulator's

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module dm_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/Vdm_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

exit 0

/* verif/dm_tb.sv */
`include "dm_consts.svh"

module dm_tb;

	localparam int WORD_BYTES    = `DM_DATA_WIDTH / 8;
	localparam int MEM_WORDS     = (1 << `DM_ADDR_WIDTH) / WORD_BYTES;
	localparam int NUM_LINES     = MEM_WORDS / `DM_BURST_LEN;
	localparam int READY_TIMEOUT = 32;
	localparam int RANDOM_STEPS  = 60;

	typedef enum logic [1:0] {
		OP_WRITE,
		OP_READ,
		OP_BUSY_WRITE
	} op_e;

	logic                      clock;
	logic                      reset;
	logic                      enable;
	logic                      read;
	logic                      write;
	logic [`DM_ADDR_WIDTH-1:0] address;
	logic [`DM_DATA_WIDTH-1:0] write_data;
	logic [`DM_DATA_WIDTH-1:0] read_data;
	logic                      read_ready;
	logic                      read_last;
	logic                      busy;

	// stimulus table with one entry per step
	string                     step_name [$];
	op_e                       step_op [$];
	logic [`DM_ADDR_WIDTH-1:0] step_addr [$];
	logic [`DM_DATA_WIDTH-1:0] step_data [$];

	// expected contents of the whole memory by word address
	logic [`DM_DATA_WIDTH-1:0] model_mem [MEM_WORDS];

	dm_subsystem dut0 (
		.clock      (clock),
		.reset      (reset),
		.enable     (enable),
		.read       (read),
		.write      (write),
		.address    (address),
		.write_data (write_data),
		.read_data  (read_data),
		.read_ready (read_ready),
		.read_last  (read_last),
		.busy       (busy)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// a burst always starts at the first word of the aligned line
	function automatic int line_first_word(input logic [`DM_ADDR_WIDTH-1:0] addr);
		int word;
		word = int'(addr) / WORD_BYTES;
		return word - (word % `DM_BURST_LEN);
	endfunction

	task automatic stop_with_failure();
		$display("TB FAILED");
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic check_word(
		input string                     name,
		input logic [`DM_DATA_WIDTH-1:0] expected,
		input logic [`DM_DATA_WIDTH-1:0] actual
	);
		if (actual !== expected) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Error: %s expected %b actual %b", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic add_step(
		input string                     name,
		input op_e                       op,
		input logic [`DM_ADDR_WIDTH-1:0] addr,
		input logic [`DM_DATA_WIDTH-1:0] data
	);
		step_name.push_back(name);
		step_op.push_back(op);
		step_addr.push_back(addr);
		step_data.push_back(data);
	endtask

	task automatic issue_request(
		input string                     name,
		input logic                      rd,
		input logic                      wr,
		input logic [`DM_ADDR_WIDTH-1:0] addr,
		input logic [`DM_DATA_WIDTH-1:0] data,
		input logic                      expect_busy
	);
		@(posedge clock);
		enable     <= 1'b1;
		read       <= rd;
		write      <= wr;
		address    <= addr;
		write_data <= data;
		// this is the busy level the DUT sees on the edge that would take the request
		@(negedge clock);
		check_flag({name, " busy"}, expect_busy, busy);
	endtask

	task automatic drive_idle();
		@(posedge clock);
		enable <= 1'b0;
		read   <= 1'b0;
		write  <= 1'b0;
	endtask

	task automatic collect_burst(input string name, input logic [`DM_ADDR_WIDTH-1:0] addr);
		int    waited;
		int    base;
		string beat;
		waited = 0;
		base   = line_first_word(addr);
		@(negedge clock);
		while (read_ready !== 1'b1) begin
			waited++;
			if (waited > READY_TIMEOUT) begin
				$display("Timeout: %s saw no read_ready within %0d cycles of the read request",
					name, READY_TIMEOUT);
				stop_with_failure();
			end
			@(negedge clock);
		end
		for (int k = 0; k < `DM_BURST_LEN; k++) begin
			beat = $sformatf("%s beat %0d", name, k);
			if (k > 0) begin
				@(negedge clock);
				check_flag({beat, " ready"}, 1'b1, read_ready);
			end
			check_flag({beat, " last"}, k == `DM_BURST_LEN - 1, read_last);
			check_word({beat, " data"}, model_mem[base + k], read_data);
		end
		// a seventeenth ready beat would mean the burst ran long
		@(negedge clock);
		check_flag({name, " ready after the last beat"}, 1'b0, read_ready);
	endtask

	initial begin
		logic [31:0] rng;
		logic [31:0] pick;

		reset      = 1'b1;
		enable     = 1'b0;
		read       = 1'b0;
		write      = 1'b0;
		address    = '0;
		write_data = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			model_mem[i] = '0;
		end

		add_step("reset_line0", OP_READ, 10'h000, '0);
		for (int i = 0; i < `DM_BURST_LEN; i++) begin
			add_step($sformatf("fill_line1_w%0d", i), OP_WRITE, 10'(64 + WORD_BYTES * i),
				32'h1000_0000 + 32'(i) * 32'h0001_0101);
		end
		add_step("read_line1", OP_READ, 10'h040, '0);
		add_step("mid_line1", OP_READ, 10'h05c, '0);

		// back to back writes are followed straight away by a read of the same line
		for (int i = 0; i < `DM_NUM_BANKS; i++) begin
			add_step($sformatf("order_w%0d", i), OP_WRITE, 10'(192 + WORD_BYTES * i),
				32'hc0de_0000 + 32'(i));
		end
		add_step("order_read", OP_READ, 10'h0c8, '0);

		add_step("busy_write", OP_BUSY_WRITE, 10'h044, 32'hdead_beef);
		add_step("busy_recheck", OP_READ, 10'h044, '0);

		rng = 32'hb97d;
		for (int i = 0; i < RANDOM_STEPS; i++) begin
			rng  = xorshift32(rng);
			pick = rng;
			rng  = xorshift32(rng);
			if (pick[31:29] == 3'd0) begin
				add_step($sformatf("random_%0d_read", i), OP_READ,
					{pick[`DM_ADDR_WIDTH-1:2], 2'b00}, '0);
			end else begin
				add_step($sformatf("random_%0d_write", i), OP_WRITE,
					{pick[`DM_ADDR_WIDTH-1:2], 2'b00}, rng);
			end
		end
		for (int l = 0; l < NUM_LINES; l++) begin
			add_step($sformatf("sweep_line%0d", l), OP_READ,
				10'(l * `DM_BURST_LEN * WORD_BYTES), '0);
		end

		repeat (4) @(posedge clock);
		reset <= 1'b0;

		// outputs straight out of reset
		@(negedge clock);
		check_flag("reset busy", 1'b0, busy);
		check_flag("reset read_ready", 1'b0, read_ready);
		check_flag("reset read_last", 1'b0, read_last);
		check_word("reset read_data", '0, read_data);

		for (int s = 0; s < step_name.size(); s++) begin
			if (step_op[s] == OP_WRITE) begin
				issue_request(step_name[s], 1'b0, 1'b1, step_addr[s], step_data[s], 1'b0);
				model_mem[int'(step_addr[s]) / WORD_BYTES] = step_data[s];
			end else if (step_op[s] == OP_READ) begin
				issue_request(step_name[s], 1'b1, 1'b0, step_addr[s], '0, 1'b0);
				drive_idle();
				collect_burst(step_name[s], step_addr[s]);
			end else begin
				// the write arrives while busy is high and is dropped, so the model keeps the old word
				issue_request(step_name[s], 1'b1, 1'b0, step_addr[s], '0, 1'b0);
				issue_request({step_name[s], " blocked"}, 1'b0, 1'b1, step_addr[s],
					step_data[s], 1'b1);
				drive_idle();
				collect_burst(step_name[s], step_addr[s]);
			end
		end
		drive_idle();

		$display("TB PASSED");
		$finish;
	end

endmodule

/* source/dm_subsystem.sv */
`include "dm_consts.svh"

module dm_subsystem
	import dm_pkg::*;
(
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      enable,
	input  logic                      read,
	input  logic                      write,
	input  logic [`DM_ADDR_WIDTH-1:0] address,
	input  logic [`DM_DATA_WIDTH-1:0] write_data,
	output logic [`DM_DATA_WIDTH-1:0] read_data,
	output logic                      read_ready,
	output logic                      read_last,
	output logic                      busy
);

	dm_req_t   req;
	logic      take;
	bank_cmd_t bank_cmd [`DM_NUM_BANKS];
	bank_rsp_t bank_rsp [`DM_NUM_BANKS];
	beat_tag_t beat_tag;

	assign req.read    = read;
	assign req.write   = write;
	assign req.address = address;
	assign req.data    = write_data;

	// requests arriving during a burst are dropped
	assign take = enable & ~busy;

	access_sequencer seq0 (
		.clock    (clock),
		.reset    (reset),
		.req      (req),
		.take     (take),
		.busy     (busy),
		.bank_cmd (bank_cmd),
		.beat_tag (beat_tag)
	);

	for (genvar b = 0; b < `DM_NUM_BANKS; b++) begin : g_bank
		memory_bank bank0 (
			.clock (clock),
			.reset (reset),
			.cmd   (bank_cmd[b]),
			.rsp   (bank_rsp[b])
		);
	end

	burst_collector col0 (
		.clock      (clock),
		.reset      (reset),
		.beat_tag   (beat_tag),
		.bank_rsp   (bank_rsp),
		.read_data  (read_data),
		.read_ready (read_ready),
		.read_last  (read_last)
	);

endmodule

/* source/burst_collector.sv */
`include "dm_consts.svh"

module burst_collector
	import dm_pkg::*;
(
	input  logic                      clock,
	input  logic                      reset,
	input  beat_tag_t                 beat_tag,
	input  bank_rsp_t                 bank_rsp [`DM_NUM_BANKS],
	output logic [`DM_DATA_WIDTH-1:0] read_data,
	output logic                      read_ready,
	output logic                      read_last
);

	beat_tag_t                 tag_d;
	logic [`DM_DATA_WIDTH-1:0] beat_word;

	// the tag is one cycle ahead of the bank's registered word
	always_ff @(posedge clock) begin
		if (reset) begin
			tag_d <= '0;
		end else begin
			tag_d <= beat_tag;
		end
	end

	assign beat_word = bank_rsp[tag_d.bank].data;

	// data holds its last value between bursts, only the strobes drop
	always_ff @(posedge clock) begin
		if (reset) begin
			read_data  <= '0;
			read_ready <= 1'b0;
			read_last  <= 1'b0;
		end else begin
			read_ready <= tag_d.valid;
			read_last  <= tag_d.valid && tag_d.last;
			if (tag_d.valid) begin
				read_data <= beat_word;
			end
		end
	end

endmodule

/* source/memory_bank.sv */
`include "dm_consts.svh"

module memory_bank
	import dm_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  bank_cmd_t cmd,
	output bank_rsp_t rsp
);

	logic [`DM_DATA_WIDTH-1:0] mem [BANK_WORDS];

	// every word is cleared so a read after reset returns zeros
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < BANK_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (cmd.write) begin
			mem[cmd.index] <= cmd.data;
		end
	end

	// read port is registered, so data follows the command by one cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			rsp <= '0;
		end else if (cmd.read) begin
			rsp.data <= mem[cmd.index];
		end
	end

endmodule

/* source/access_sequencer.sv */
`include "dm_consts.svh"

module access_sequencer
	import dm_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  dm_req_t   req,
	input  logic      take,
	output logic      busy,
	output bank_cmd_t bank_cmd [`DM_NUM_BANKS],
	output beat_tag_t beat_tag
);

	// the last stage of the wait-state delay line is the one leaving
	dm_req_t                   line_req [`DM_WAIT_STATE];
	logic [`DM_WAIT_STATE-1:0] line_valid;
	dm_req_t                   taken_req;
	dm_req_t                   out_req;
	logic                      out_valid;

	// burst in progress
	logic                 burst_active;
	logic [BEAT_BITS-1:0] beat_count;
	logic [LINE_BITS-1:0] line_base;
	logic                 beat_last;

	// the access chosen for this cycle, before it is split across banks
	logic                      issue_valid;
	logic                      issue_read;
	logic                      issue_write;
	logic [WORD_BITS-1:0]      issue_word;
	logic [`DM_DATA_WIDTH-1:0] issue_data;
	logic [BANK_BITS-1:0]      issue_bank;
	logic [INDEX_BITS-1:0]     issue_index;
	bank_cmd_t                 next_cmd [`DM_NUM_BANKS];

	// a read wins when both strobes are high, so the write is dropped here
	always_comb begin
		taken_req = req;
		taken_req.write = req.write && !req.read;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
		end else begin
			line_valid[0] <= take && (req.read || req.write);
			for (int i = 1; i < `DM_WAIT_STATE; i++) begin
				line_valid[i] <= line_valid[i-1];
			end
		end
	end

	always_ff @(posedge clock) begin
		line_req[0] <= taken_req;
		for (int i = 1; i < `DM_WAIT_STATE; i++) begin
			line_req[i] <= line_req[i-1];
		end
	end

	assign out_req   = line_req[`DM_WAIT_STATE-1];
	assign out_valid = line_valid[`DM_WAIT_STATE-1];

	assign beat_last = beat_count == BEAT_BITS'(`DM_BURST_LEN - 1);

	// busy covers the read from the edge it is taken until its final beat goes out
	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (take && req.read) begin
			busy <= 1'b1;
		end else if (burst_active && beat_last) begin
			busy <= 1'b0;
		end
	end

	// the line base is captured as the read leaves the delay line
	always_ff @(posedge clock) begin
		if (reset) begin
			burst_active <= 1'b0;
			beat_count   <= '0;
			line_base    <= '0;
		end else if (burst_active) begin
			beat_count <= beat_count + 1'b1;
			if (beat_last) begin
				burst_active <= 1'b0;
			end
		end else if (out_valid && out_req.read) begin
			burst_active <= 1'b1;
			beat_count   <= '0;
			line_base    <= out_req.address[`DM_ADDR_WIDTH-1 -: LINE_BITS];
		end
	end

	// no write can leave the line during a burst since busy blocks new requests
	always_comb begin
		issue_valid = 1'b0;
		issue_read  = 1'b0;
		issue_write = 1'b0;
		issue_word  = out_req.address[`DM_ADDR_WIDTH-1:BYTE_BITS];
		issue_data  = out_req.data;
		if (burst_active) begin
			issue_valid = 1'b1;
			issue_read  = 1'b1;
			issue_word  = {line_base, beat_count};
		end else if (out_valid && out_req.write) begin
			issue_valid = 1'b1;
			issue_write = 1'b1;
		end
	end

	// low word bits pick the bank, the rest index into it
	assign issue_bank  = issue_word[BANK_BITS-1:0];
	assign issue_index = issue_word[WORD_BITS-1:BANK_BITS];

	always_comb begin
		for (int b = 0; b < `DM_NUM_BANKS; b++) begin
			next_cmd[b] = '0;
			next_cmd[b].index = issue_index;
			next_cmd[b].data  = issue_data;
			if (issue_valid && issue_bank == BANK_BITS'(b)) begin
				next_cmd[b].read  = issue_read;
				next_cmd[b].write = issue_write;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int b = 0; b < `DM_NUM_BANKS; b++) begin
				bank_cmd[b] <= '0;
			end
			beat_tag <= '0;
		end else begin
			for (int b = 0; b < `DM_NUM_BANKS; b++) begin
				bank_cmd[b] <= next_cmd[b];
			end
			beat_tag.valid <= burst_active;
			beat_tag.bank  <= issue_bank;
			beat_tag.last  <= burst_active && beat_last;
		end
	end

endmodule

/* source/dm_pkg.sv */
`include "dm_consts.svh"

package dm_pkg;

	// address splits derived from the constants header
	localparam int BYTE_BITS  = $clog2(`DM_DATA_WIDTH / 8);
	localparam int WORD_BITS  = `DM_ADDR_WIDTH - BYTE_BITS;
	localparam int BEAT_BITS  = $clog2(`DM_BURST_LEN);
	localparam int LINE_BITS  = WORD_BITS - BEAT_BITS;
	localparam int BANK_BITS  = $clog2(`DM_NUM_BANKS);
	localparam int INDEX_BITS = WORD_BITS - BANK_BITS;
	localparam int BANK_WORDS = 1 << INDEX_BITS;

	// one request as seen at the pins
	typedef struct packed {
		logic                      read;
		logic                      write;
		logic [`DM_ADDR_WIDTH-1:0] address;
		logic [`DM_DATA_WIDTH-1:0] data;
	} dm_req_t;

	// one command to a single bank
	typedef struct packed {
		logic                      read;
		logic                      write;
		logic [INDEX_BITS-1:0]     index;
		logic [`DM_DATA_WIDTH-1:0] data;
	} bank_cmd_t;

	// registered read word of one bank
	typedef struct packed {
		logic [`DM_DATA_WIDTH-1:0] data;
	} bank_rsp_t;

	// travels alongside each read beat so the collector knows which bank answers
	typedef struct packed {
		logic                 valid;
		logic [BANK_BITS-1:0] bank;
		logic                 last;
	} beat_tag_t;

endpackage

/* include/dm_consts.svh */
`ifndef DM_CONSTS_SVH
`define DM_CONSTS_SVH

// cycles a taken request spends in the delay line before it reaches the banks
`define DM_WAIT_STATE 2

// width of one memory word in bits
`define DM_DATA_WIDTH 32

// byte address width giving 1 KiB or 256 words
`define DM_ADDR_WIDTH 10

// a burst read returns this many words so a line is 64 bytes
`define DM_BURST_LEN 16

// consecutive words land in consecutive word-interleaved banks
`define DM_NUM_BANKS 4

`endif
